// File: rtl/qrd_pkg.sv
package qrd_pkg;

    // Sample width at the top level ports
    localparam int DATA_WIDTH = 14;

    // Micro-rotations with shift amounts 0 .. ITER-1
    localparam int ITER = 12;
    localparam int ITER_WIDTH = $clog2(ITER);

    // Inverse CORDIC gain of 622 / 1024 ~ 0.6074
    localparam int GAIN_FRAC = 10;
    localparam int GAIN_COEF = 622;

    // Controller states
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        ITERATE = 2'd1,
        SCALE   = 2'd2,
        DONE    = 2'd3
    } ctrl_state_t;

endpackage

// File: rtl/iter_counter.sv
`timescale 1ns/1ps

module iter_counter #(
    parameter int ITER = 12
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           clear_i,
    input  logic                           en_i,
    output logic [qrd_pkg::ITER_WIDTH-1:0] idx_o,
    output logic                           last_o
);

    localparam logic [qrd_pkg::ITER_WIDTH-1:0] IDX_LAST = qrd_pkg::ITER_WIDTH'(ITER - 1);

    assign last_o = (idx_o == IDX_LAST);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx_o <= '0;
        end else if (clear_i) begin
            idx_o <= '0;
        end else if (en_i) begin
            // Wrap after the final micro-rotation
            if (last_o) begin
                idx_o <= '0;
            end else begin
                idx_o <= idx_o + 1'b1;
            end
        end
    end

    a_idx_range: assert property (
        @(posedge clk) disable iff (!rst_n) idx_o <= IDX_LAST
    );

endmodule

// File: rtl/qrd_ctrl.sv
`timescale 1ns/1ps

module qrd_ctrl #(
    parameter int ITER = 12
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start_i,
    input  logic last_i,
    output logic in_ready_o,
    output logic out_valid_o,
    output logic load_o,
    output logic iter_en_o,
    output logic scale_en_o
);

    qrd_pkg::ctrl_state_t state_r;
    qrd_pkg::ctrl_state_t state_nxt;

    always_comb begin
        state_nxt = state_r;
        case (state_r)
            qrd_pkg::IDLE: begin
                if (start_i) begin
                    state_nxt = qrd_pkg::ITERATE;
                end
            end
            qrd_pkg::ITERATE: begin
                if (last_i) begin
                    state_nxt = qrd_pkg::SCALE;
                end
            end
            qrd_pkg::SCALE: state_nxt = qrd_pkg::DONE;
            qrd_pkg::DONE:  state_nxt = qrd_pkg::IDLE;
            default:        state_nxt = qrd_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_r <= qrd_pkg::IDLE;
        end else begin
            state_r <= state_nxt;
        end
    end

    assign in_ready_o  = (state_r == qrd_pkg::IDLE);
    assign load_o      = in_ready_o && start_i;  // Start accepted
    assign iter_en_o   = (state_r == qrd_pkg::ITERATE);
    assign scale_en_o  = (state_r == qrd_pkg::SCALE);
    assign out_valid_o = (state_r == qrd_pkg::DONE);

    a_ready_valid_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(in_ready_o && out_valid_o)
    );

    // Load, ITER iterations, scale, then the done cycle
    a_latency: assert property (
        @(posedge clk) disable iff (!rst_n) load_o |-> ##(ITER + 2) out_valid_o
    );

endmodule

// File: rtl/cordic_vectoring.sv
`timescale 1ns/1ps

module cordic_vectoring #(
    parameter int WIDTH = 14
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           load_i,
    input  logic                           iter_en_i,
    input  logic                           scale_en_i,
    input  logic [qrd_pkg::ITER_WIDTH-1:0] idx_i,
    input  logic signed [WIDTH-1:0]        x_i,
    input  logic signed [WIDTH-1:0]        y_i,
    output logic                           dir_o,
    output logic                           neg_o,
    output logic signed [WIDTH-1:0]        mag_o
);

    localparam int GW = qrd_pkg::GAIN_FRAC + 2;
    localparam logic signed [GW-1:0] GAIN = GW'(qrd_pkg::GAIN_COEF);

    logic signed [WIDTH-1:0]    x_r;
    logic signed [WIDTH-1:0]    y_r;
    logic signed [WIDTH-1:0]    x_sft;
    logic signed [WIDTH-1:0]    y_sft;
    logic signed [WIDTH-1:0]    x_nxt;
    logic signed [WIDTH-1:0]    y_nxt;
    logic signed [WIDTH+GW-1:0] x_prod;

    // Left half plane gets mirrored onto the right
    assign neg_o = x_i[WIDTH-1];

    // Rotate towards the x axis
    assign dir_o = !y_r[WIDTH-1];

    assign x_sft = x_r >>> idx_i;
    assign y_sft = y_r >>> idx_i;

    assign x_nxt = dir_o ? (x_r + y_sft) : (x_r - y_sft);
    assign y_nxt = dir_o ? (y_r - x_sft) : (y_r + x_sft);

    assign x_prod = x_r * GAIN;

    always_ff @(posedge clk) begin
        if (load_i) begin
            x_r <= neg_o ? -x_i : x_i;
            y_r <= neg_o ? -y_i : y_i;
        end else if (iter_en_i) begin
            x_r <= x_nxt;
            y_r <= y_nxt;
        end
    end

    // y is near zero here and not kept
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mag_o <= '0;
        end else if (scale_en_i) begin
            mag_o <= WIDTH'(x_prod >>> qrd_pkg::GAIN_FRAC);
        end
    end

    a_x_nonneg: assert property (
        @(posedge clk) disable iff (!rst_n) load_i |=> !x_r[WIDTH-1]
    );

endmodule

// File: rtl/cordic_rotation.sv
`timescale 1ns/1ps

module cordic_rotation #(
    parameter int WIDTH = 14
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           load_i,
    input  logic                           iter_en_i,
    input  logic                           scale_en_i,
    input  logic                           dir_i,
    input  logic                           neg_i,
    input  logic [qrd_pkg::ITER_WIDTH-1:0] idx_i,
    input  logic signed [WIDTH-1:0]        x_i,
    input  logic signed [WIDTH-1:0]        y_i,
    output logic signed [WIDTH-1:0]        x_o,
    output logic signed [WIDTH-1:0]        y_o
);

    localparam int GW = qrd_pkg::GAIN_FRAC + 2;
    localparam logic signed [GW-1:0] GAIN = GW'(qrd_pkg::GAIN_COEF);

    logic signed [WIDTH-1:0]    x_r;
    logic signed [WIDTH-1:0]    y_r;
    logic signed [WIDTH-1:0]    x_sft;
    logic signed [WIDTH-1:0]    y_sft;
    logic signed [WIDTH+GW-1:0] x_prod;
    logic signed [WIDTH+GW-1:0] y_prod;

    assign x_sft = x_r >>> idx_i;
    assign y_sft = y_r >>> idx_i;

    assign x_prod = x_r * GAIN;
    assign y_prod = y_r * GAIN;

    always_ff @(posedge clk) begin
        if (load_i) begin
            x_r <= neg_i ? -x_i : x_i;  // Same mirror as the first column
            y_r <= neg_i ? -y_i : y_i;
        end else if (iter_en_i) begin
            // Steered by the vectoring engine, in lockstep
            x_r <= dir_i ? (x_r + y_sft) : (x_r - y_sft);
            y_r <= dir_i ? (y_r - x_sft) : (y_r + x_sft);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x_o <= '0;
            y_o <= '0;
        end else if (scale_en_i) begin
            x_o <= WIDTH'(x_prod >>> qrd_pkg::GAIN_FRAC);
            y_o <= WIDTH'(y_prod >>> qrd_pkg::GAIN_FRAC);
        end
    end

endmodule

// File: rtl/qrd_top.sv
`timescale 1ns/1ps

module qrd_top #(
    parameter int WIDTH = qrd_pkg::DATA_WIDTH,
    parameter int ITER  = qrd_pkg::ITER
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    input  logic signed [WIDTH-1:0] a11_i,
    input  logic signed [WIDTH-1:0] a21_i,
    input  logic signed [WIDTH-1:0] a12_i,
    input  logic signed [WIDTH-1:0] a22_i,
    output logic                    in_ready_o,
    output logic                    out_valid_o,
    output logic signed [WIDTH-1:0] r11_o,
    output logic signed [WIDTH-1:0] r12_o,
    output logic signed [WIDTH-1:0] r22_o
);

    logic                           load;
    logic                           iter_en;
    logic                           scale_en;
    logic                           last;
    logic [qrd_pkg::ITER_WIDTH-1:0] idx;
    logic                           dir;
    logic                           neg;

    qrd_ctrl #(.ITER(ITER)) u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .last_i     (last),
        .in_ready_o (in_ready_o),
        .out_valid_o(out_valid_o),
        .load_o     (load),
        .iter_en_o  (iter_en),
        .scale_en_o (scale_en)
    );

    iter_counter #(.ITER(ITER)) u_cnt (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear_i(load),
        .en_i   (iter_en),
        .idx_o  (idx),
        .last_o (last)
    );

    // First column engine zeroes a21
    cordic_vectoring #(.WIDTH(WIDTH)) u_vec (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_i    (load),
        .iter_en_i (iter_en),
        .scale_en_i(scale_en),
        .idx_i     (idx),
        .x_i       (a11_i),
        .y_i       (a21_i),
        .dir_o     (dir),
        .neg_o     (neg),
        .mag_o     (r11_o)
    );

    cordic_rotation #(.WIDTH(WIDTH)) u_rot (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_i    (load),
        .iter_en_i (iter_en),
        .scale_en_i(scale_en),
        .dir_i     (dir),
        .neg_i     (neg),
        .idx_i     (idx),
        .x_i       (a12_i),
        .y_i       (a22_i),
        .x_o       (r12_o),
        .y_o       (r22_o)
    );

endmodule

// File: sim/qrd_model.svh
`ifndef QRD_MODEL_SVH
`define QRD_MODEL_SVH

// Two's complement wrap to the sample width
function automatic int wrap_sample(input int v);
    int m;
    int r;
    m = 1 << qrd_pkg::DATA_WIDTH;
    r = v & (m - 1);
    if (r >= m / 2) begin
        r = r - m;
    end
    return r;
endfunction

// Fixed point multiply by the inverse gain then arithmetic shift
function automatic int gain_scale(input int v);
    return wrap_sample((v * qrd_pkg::GAIN_COEF) >>> qrd_pkg::GAIN_FRAC);
endfunction

// One Givens rotation of a real 2x2 matrix that takes the first column onto the x axis
function automatic void givens_model(
    input  int a11,
    input  int a21,
    input  int a12,
    input  int a22,
    output int r11,
    output int r12,
    output int r22
);
    int vx;
    int vy;
    int rx;
    int ry;
    int vx_n;
    int vy_n;
    int rx_n;
    int ry_n;
    vx = wrap_sample(a11);
    vy = wrap_sample(a21);
    rx = wrap_sample(a12);
    ry = wrap_sample(a22);
    if (vx < 0) begin  // Quadrant correction
        vx = wrap_sample(-vx);
        vy = wrap_sample(-vy);
        rx = wrap_sample(-rx);
        ry = wrap_sample(-ry);
    end
    for (int i = 0; i < qrd_pkg::ITER; i++) begin
        if (vy >= 0) begin
            vx_n = vx + (vy >>> i);
            vy_n = vy - (vx >>> i);
            rx_n = rx + (ry >>> i);
            ry_n = ry - (rx >>> i);
        end else begin
            vx_n = vx - (vy >>> i);
            vy_n = vy + (vx >>> i);
            rx_n = rx - (ry >>> i);
            ry_n = ry + (rx >>> i);
        end
        vx = wrap_sample(vx_n);
        vy = wrap_sample(vy_n);
        rx = wrap_sample(rx_n);
        ry = wrap_sample(ry_n);
    end
    r11 = gain_scale(vx);
    r12 = gain_scale(rx);
    r22 = gain_scale(ry);  // Vectoring y is dropped
endfunction

`endif

// File: sim/qrd_tb.sv
`timescale 1ns/1ps

module qrd_tb;

    localparam int W          = qrd_pkg::DATA_WIDTH;
    localparam int ITER       = qrd_pkg::ITER;
    localparam int LIM        = 1 << (W - 3);  // Input magnitudes stay below this
    localparam int CLK_PERIOD = 8;
    localparam int LATENCY    = ITER + 2;      // Cycles from the accepting edge to out_valid

    localparam int N_RANDOM = 200;
    localparam int N_NEG    = 40;
    localparam int N_EDGE   = 8;
    localparam int N_FLOW   = 10;
    localparam int N_HOLD   = 20;
    localparam int N_TRANS  = N_RANDOM + N_NEG + N_EDGE + N_FLOW + N_HOLD;

    // Idle gaps of the flow and hold tests come on top of the transactions
    localparam int IDLE_CYCLES     = N_FLOW * (ITER + 4) + N_HOLD * 8;
    localparam int WATCHDOG_CYCLES = N_TRANS * (ITER + 6) + IDLE_CYCLES + 200;

    logic                clk;
    logic                rst_n;
    logic                start_i;
    logic signed [W-1:0] a11_i;
    logic signed [W-1:0] a21_i;
    logic signed [W-1:0] a12_i;
    logic signed [W-1:0] a22_i;
    logic                in_ready_o;
    logic                out_valid_o;
    logic signed [W-1:0] r11_o;
    logic signed [W-1:0] r12_o;
    logic signed [W-1:0] r22_o;

    int errors;
    int checks;
    int trans;
    int prev_r11;  // Last results that must hold while idle
    int prev_r12;
    int prev_r22;

    `include "qrd_model.svh"

    qrd_top #(.WIDTH(W), .ITER(ITER)) uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .a11_i      (a11_i),
        .a21_i      (a21_i),
        .a12_i      (a12_i),
        .a22_i      (a22_i),
        .in_ready_o (in_ready_o),
        .out_valid_o(out_valid_o),
        .r11_o      (r11_o),
        .r12_o      (r12_o),
        .r22_o      (r22_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_val(input string what, input logic signed [31:0] got,
                             input logic signed [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic int rand_sample();
        return int'($urandom % (2 * LIM - 1)) - (LIM - 1);
    endfunction

    // Called on a rising edge
    task automatic scramble_inputs();
        a11_i <= W'(rand_sample());
        a21_i <= W'(rand_sample());
        a12_i <= W'(rand_sample());
        a22_i <= W'(rand_sample());
    endtask

    task automatic check_results_held(input string when);
        check_val({"r11_o ", when}, r11_o, prev_r11);
        check_val({"r12_o ", when}, r12_o, prev_r12);
        check_val({"r22_o ", when}, r22_o, prev_r22);
    endtask

    // One accepted start and its result with an optional start pulse while busy
    task automatic run_transaction(input int a11, input int a21, input int a12,
                                   input int a22, input bit poke);
        int  e11;
        int  e12;
        int  e22;
        int  cyc;
        bit  seen;
        time t_acc;
        givens_model(a11, a21, a12, a22, e11, e12, e22);
        @(negedge clk);
        while (!in_ready_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        start_i <= 1'b1;
        a11_i   <= W'(a11);
        a21_i   <= W'(a21);
        a12_i   <= W'(a12);
        a22_i   <= W'(a22);
        @(posedge clk);  // Accepting edge
        t_acc = $time;
        start_i <= 1'b0;
        scramble_inputs();
        cyc  = 0;
        seen = 1'b0;
        while (!seen && cyc < LATENCY + 4) begin
            @(negedge clk);
            cyc++;
            if (out_valid_o) begin
                seen = 1'b1;
            end else begin
                check_val("in_ready_o while busy", in_ready_o, 0);
                check_results_held("while busy");
                if (poke && cyc == 3) begin
                    @(posedge clk);
                    start_i <= 1'b1;
                    scramble_inputs();
                end else if (poke && cyc == 4) begin
                    @(posedge clk);
                    start_i <= 1'b0;
                end
            end
        end
        if (!seen) begin
            errors++;
            $display("No out_valid pulse within %0d cycles of the start accepted at %0d ns",
                     LATENCY + 4, t_acc);
        end else begin
            check_val("out_valid_o latency", cyc, LATENCY);
            check_val("in_ready_o during done", in_ready_o, 0);
            check_val("r11_o", r11_o, e11);
            check_val("r12_o", r12_o, e12);
            check_val("r22_o", r22_o, e22);
            @(negedge clk);
            check_val("out_valid_o pulse length", out_valid_o, 0);
            check_val("in_ready_o after done", in_ready_o, 1);
        end
        prev_r11 = e11;
        prev_r12 = e12;
        prev_r22 = e22;
        trans++;
    endtask

    // Idle cycles with moving inputs and quiet outputs
    task automatic idle_hold(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            scramble_inputs();
            @(negedge clk);
            check_val("out_valid_o while idle", out_valid_o, 0);
            check_val("in_ready_o while idle", in_ready_o, 1);
            check_results_held("while idle");
        end
    endtask

    task automatic report_test(input string name, input int n, input int err_mark);
        $display("%-16s %0d transactions, %0d errors", name, n, errors - err_mark);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int err_mark;
        int a11;
        errors   = 0;
        checks   = 0;
        trans    = 0;
        prev_r11 = 0;
        prev_r12 = 0;
        prev_r22 = 0;
        void'($urandom(32'h4157627f));
        clk     = 1'b0;
        rst_n   = 1'b0;
        start_i = 1'b0;
        a11_i   = '0;
        a21_i   = '0;
        a12_i   = '0;
        a22_i   = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        err_mark = errors;
        @(negedge clk);
        check_val("in_ready_o after reset", in_ready_o, 1);
        check_val("out_valid_o after reset", out_valid_o, 0);
        check_results_held("after reset");
        report_test("reset state", 0, err_mark);

        err_mark = errors;
        for (int n = 0; n < N_RANDOM; n++) begin
            run_transaction(rand_sample(), rand_sample(), rand_sample(), rand_sample(), 1'b0);
        end
        report_test("random matrices", N_RANDOM, err_mark);

        err_mark = errors;
        for (int n = 0; n < N_NEG; n++) begin
            a11 = -(1 + int'($urandom % (LIM - 1)));
            run_transaction(a11, rand_sample(), rand_sample(), rand_sample(), 1'b0);
            check_val("r11_o sign bit", r11_o[W-1], 0);
        end
        report_test("negative a11", N_NEG, err_mark);

        err_mark = errors;
        run_transaction(0, 0, rand_sample(), rand_sample(), 1'b0);  // Zero column
        run_transaction(-(LIM - 1), 0, rand_sample(), rand_sample(), 1'b0);
        run_transaction(LIM - 1, 0, rand_sample(), rand_sample(), 1'b0);
        run_transaction(LIM - 1, LIM - 1, LIM - 1, LIM - 1, 1'b0);
        run_transaction(-(LIM - 1), -(LIM - 1), -(LIM - 1), -(LIM - 1), 1'b0);
        run_transaction(-(LIM - 1), LIM - 1, LIM - 1, -(LIM - 1), 1'b0);
        run_transaction(0, -(LIM - 1), LIM - 1, LIM - 1, 1'b0);
        run_transaction(1, -1, -(LIM - 1), LIM - 1, 1'b0);
        report_test("edge columns", N_EDGE, err_mark);

        err_mark = errors;
        for (int n = 0; n < N_FLOW; n++) begin
            run_transaction(rand_sample(), rand_sample(), rand_sample(), rand_sample(), 1'b1);
            idle_hold(ITER + 4);  // A wrongly accepted start would show up here
        end
        report_test("flow control", N_FLOW, err_mark);

        err_mark = errors;
        for (int n = 0; n < N_HOLD; n++) begin
            run_transaction(rand_sample(), rand_sample(), rand_sample(), rand_sample(), 1'b0);
            idle_hold(1 + int'($urandom % 6));
        end
        report_test("result hold", N_HOLD, err_mark);

        $display("Summary: %0d transactions, %0d checks, %0d errors", trans, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+sim
rtl/qrd_pkg.sv
rtl/iter_counter.sv
rtl/qrd_ctrl.sv
rtl/cordic_vectoring.sv
rtl/cordic_rotation.sv
rtl/qrd_top.sv
sim/qrd_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal -j 0 --top-module qrd_tb -Mdir obj_dir -f vlog.f
	./obj_dir/Vqrd_tb | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
